/* rtl/fifo_sync_pkg.sv */
package fifo_sync_pkg;

   // --------------------------------------------------
   // Sizing
   // --------------------------------------------------
   localparam int ADDR_W     = 10;
   localparam int FIFO_DEPTH = 1 << ADDR_W;   // 1024 entries
   localparam int PTR_W      = ADDR_W + 1;    // Extra bit tells full from empty

   // Static thresholds
   localparam int AFULL_VAL  = 1020;
   localparam int AEMPTY_VAL = 4;

   // --------------------------------------------------
   // Types
   // --------------------------------------------------
   typedef logic [ADDR_W-1:0] addr_t;         // Memory word address
   typedef logic [PTR_W-1:0]  ptr_t;          // Pointer or occupancy

   // Registered level flags
   typedef struct packed {
      logic full;
      logic afull;
      logic empty;
      logic aempty;
   } level_flags_t;

   // Single cycle pulses
   typedef struct packed {
      logic wack;
      logic dvld;
      logic overflow;
      logic underflow;
   } event_flags_t;

   // External dual-port memory
   typedef struct packed {
      addr_t waddr;
      logic  we;
      addr_t raddr;
      logic  re;
   } mem_port_t;

endpackage

/* rtl/fifo_sync_ctrl.sv */
`timescale 1ns/1ps

module fifo_sync_ctrl (
   input  logic                        pos_clk,
   input  logic                        aresetn,
   input  logic                        we_i,       // Write request
   input  logic                        re_i,       // Read request
   input  logic                        full_i,     // Registered full
   input  logic                        empty_i,    // Registered empty
   output logic                        wr_acc_o,   // Write goes through
   output logic                        rd_acc_o,   // Read goes through
   output fifo_sync_pkg::event_flags_t events_o
);

   import fifo_sync_pkg::*;

   event_flags_t events_d;
   event_flags_t events_q;
   logic         wr_blocked;
   logic         rd_blocked;

   // --------------------------------------------------
   // Request gating
   // --------------------------------------------------

   // A write is blocked while full, a read while empty.
   // Blocked requests are simply dropped.
   assign wr_acc_o   = we_i & ~full_i;
   assign rd_acc_o   = re_i & ~empty_i;

   assign wr_blocked = we_i & full_i;
   assign rd_blocked = re_i & empty_i;

   // --------------------------------------------------
   // Handshake and error pulses
   // --------------------------------------------------
   always_comb begin
      events_d           = '0;
      events_d.wack      = wr_acc_o;
      events_d.dvld      = rd_acc_o;
      events_d.overflow  = wr_blocked;   // Write into a full FIFO
      events_d.underflow = rd_blocked;   // Read from an empty FIFO
   end

   // One cycle behind the request
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         events_q <= '0;
      end else begin
         events_q <= events_d;
      end
   end

   assign events_o = events_q;

endmodule

/* rtl/fifo_wr_side.sv */
`timescale 1ns/1ps

module fifo_wr_side (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 wr_acc_i,    // Accepted write
   input  logic                 wr_req_i,    // Raw request for full look-ahead
   input  fifo_sync_pkg::ptr_t  rd_ptr_i,    // Registered read pointer
   output fifo_sync_pkg::ptr_t  wr_ptr_o,
   output fifo_sync_pkg::addr_t waddr_o,
   output logic                 full_o,
   output logic                 afull_o
);

   import fifo_sync_pkg::*;

   ptr_t wr_ptr_q;
   ptr_t wdiff;
   logic wr_landing;
   logic full_nxt;
   logic afull_nxt;
   logic full_q;
   logic afull_q;

   // --------------------------------------------------
   // Write pointer
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_ptr_q <= '0;
      end else if (wr_acc_i) begin
         wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
   end

   // Low bits wrap at the memory depth on their own
   assign waddr_o  = wr_ptr_q[ADDR_W-1:0];
   assign wr_ptr_o = wr_ptr_q;

   // --------------------------------------------------
   // Flag generation
   // --------------------------------------------------

   // Entries held, seen from the write side
   assign wdiff = wr_ptr_q - rd_ptr_i;

   // Request that really lands this cycle.
   // A request held while full must not keep the flag set.
   assign wr_landing = wr_req_i & ~full_q;

   // Look one write ahead so full rises with the last write
   always_comb begin
      if (wr_landing) begin
         full_nxt = (wdiff >= ptr_t'(FIFO_DEPTH - 1));
      end else begin
         full_nxt = (wdiff >= ptr_t'(FIFO_DEPTH));
      end
   end

   assign afull_nxt = (wdiff >= ptr_t'(AFULL_VAL - 1));   // One cycle late

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_q  <= 1'b0;
         afull_q <= 1'b0;
      end else begin
         full_q  <= full_nxt;
         afull_q <= afull_nxt;
      end
   end

   assign full_o  = full_q;
   assign afull_o = afull_q;

endmodule

/* rtl/fifo_rd_side.sv */
`timescale 1ns/1ps

module fifo_rd_side (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 rd_acc_i,    // Accepted read
   input  logic                 rd_req_i,    // Raw request for empty look-ahead
   input  fifo_sync_pkg::ptr_t  wr_ptr_i,    // Registered write pointer
   output fifo_sync_pkg::ptr_t  rd_ptr_o,
   output fifo_sync_pkg::addr_t raddr_o,
   output logic                 empty_o,
   output logic                 aempty_o,
   output fifo_sync_pkg::ptr_t  count_o      // Occupancy, one cycle late
);

   import fifo_sync_pkg::*;

   ptr_t rd_ptr_q;
   ptr_t rdiff;
   ptr_t count_q;
   logic rd_landing;
   logic empty_nxt;
   logic aempty_nxt;
   logic empty_q;
   logic aempty_q;

   // --------------------------------------------------
   // Read pointer
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_ptr_q <= '0;
      end else if (rd_acc_i) begin
         rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
   end

   assign raddr_o  = rd_ptr_q[ADDR_W-1:0];   // Wraps with the pointer
   assign rd_ptr_o = rd_ptr_q;

   // --------------------------------------------------
   // Flag generation
   // --------------------------------------------------

   // Entries held, seen from the read side
   assign rdiff = wr_ptr_i - rd_ptr_q;

   // Only a read that gets past the empty check counts
   assign rd_landing = rd_req_i & ~empty_q;

   // With one entry left the request decides.
   // Otherwise empty tracks a zero difference, so it falls
   // one cycle after the first write lands.
   always_comb begin
      if (rdiff == ptr_t'(1)) begin
         empty_nxt = rd_landing;
      end else begin
         empty_nxt = (rdiff == '0);
      end
   end

   assign aempty_nxt = (rdiff <= ptr_t'(AEMPTY_VAL + 1));

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         empty_q  <= 1'b1;
         aempty_q <= 1'b1;
      end else begin
         empty_q  <= empty_nxt;
         aempty_q <= aempty_nxt;
      end
   end

   // --------------------------------------------------
   // Occupancy count
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_q <= '0;
      end else begin
         count_q <= rdiff;
      end
   end

   assign empty_o  = empty_q;
   assign aempty_o = aempty_q;
   assign count_o  = count_q;

endmodule

/* rtl/fifo_sync.sv */
`timescale 1ns/1ps

module fifo_sync (
   input  logic                        pos_clk,
   input  logic                        aresetn,
   input  logic                        we_i,       // Write request, active high
   input  logic                        re_i,       // Read request, active high
   output fifo_sync_pkg::level_flags_t level_o,
   output fifo_sync_pkg::event_flags_t events_o,
   output fifo_sync_pkg::ptr_t         count_o,
   output fifo_sync_pkg::mem_port_t    mem_o
);

   import fifo_sync_pkg::*;

   logic  wr_acc;
   logic  rd_acc;
   logic  full;
   logic  afull;
   logic  empty;
   logic  aempty;
   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   addr_t waddr;
   addr_t raddr;

   // --------------------------------------------------
   // Request gating and pulses
   // --------------------------------------------------
   fifo_sync_ctrl u_ctrl (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .we_i     (we_i),
      .re_i     (re_i),
      .full_i   (full),
      .empty_i  (empty),
      .wr_acc_o (wr_acc),
      .rd_acc_o (rd_acc),
      .events_o (events_o)
   );

   // --------------------------------------------------
   // Write and read sides
   // --------------------------------------------------
   fifo_wr_side u_wr_side (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_acc_i (wr_acc),
      .wr_req_i (we_i),
      .rd_ptr_i (rd_ptr),
      .wr_ptr_o (wr_ptr),
      .waddr_o  (waddr),
      .full_o   (full),
      .afull_o  (afull)
   );

   fifo_rd_side u_rd_side (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .rd_acc_i (rd_acc),
      .rd_req_i (re_i),
      .wr_ptr_i (wr_ptr),
      .rd_ptr_o (rd_ptr),
      .raddr_o  (raddr),
      .empty_o  (empty),
      .aempty_o (aempty),
      .count_o  (count_o)
   );

   // Output bundles
   assign level_o = '{full: full, afull: afull, empty: empty, aempty: aempty};

   // Enables are the accept strobes, same cycle as the request
   assign mem_o   = '{waddr: waddr, we: wr_acc, raddr: raddr, re: rd_acc};

endmodule

/* verif/fifo_sync_tb_tasks.svh */
// --------------------------------------------------
// Check helpers
// --------------------------------------------------
task automatic report_mismatch(input string what, input int got, input int exp);
   $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
   err_count++;
endtask

task automatic report_problem(input string msg);
   $display("Error at time %0t: %s", $time, msg);
   err_count++;
endtask

// Every output against the model, sampled mid cycle
task automatic compare_outputs(input logic exp_we, input logic exp_re);
   if (mem_o.we !== exp_we) report_mismatch("mem_o.we", mem_o.we, exp_we);
   if (mem_o.re !== exp_re) report_mismatch("mem_o.re", mem_o.re, exp_re);
   if (mem_o.waddr !== m_waddr[ADDR_W-1:0])
      report_mismatch("mem_o.waddr", mem_o.waddr, m_waddr);
   if (mem_o.raddr !== m_raddr[ADDR_W-1:0])
      report_mismatch("mem_o.raddr", mem_o.raddr, m_raddr);
   if (level_o.full !== m_full) report_mismatch("full", level_o.full, m_full);
   if (level_o.afull !== m_afull) report_mismatch("afull", level_o.afull, m_afull);
   if (level_o.empty !== m_empty) report_mismatch("empty", level_o.empty, m_empty);
   if (level_o.aempty !== m_aempty) report_mismatch("aempty", level_o.aempty, m_aempty);
   if (events_o.wack !== m_events.wack)
      report_mismatch("wack", events_o.wack, m_events.wack);
   if (events_o.dvld !== m_events.dvld)
      report_mismatch("dvld", events_o.dvld, m_events.dvld);
   if (events_o.overflow !== m_events.overflow)
      report_mismatch("overflow", events_o.overflow, m_events.overflow);
   if (events_o.underflow !== m_events.underflow)
      report_mismatch("underflow", events_o.underflow, m_events.underflow);
   if (count_o !== m_count[PTR_W-1:0]) report_mismatch("count_o", count_o, m_count);
endtask

// One clock cycle of requests, checked and then folded into the model
task automatic drive_cycle(input logic we, input logic re);
   logic exp_we;
   logic exp_re;
   @(posedge pos_clk);
   we_i <= we;
   re_i <= re;
   @(negedge pos_clk);        // Outputs settled
   exp_we = we & ~m_full;     // Protected mode
   exp_re = re & ~m_empty;
   compare_outputs(exp_we, exp_re);
   advance_model(we, re, exp_we, exp_re);
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic check_reset_state();
   @(negedge pos_clk);
   if (level_o.empty !== 1'b1) report_mismatch("empty after reset", level_o.empty, 1);
   if (level_o.aempty !== 1'b1) report_mismatch("aempty after reset", level_o.aempty, 1);
   if (level_o.full !== 1'b0) report_mismatch("full after reset", level_o.full, 0);
   if (level_o.afull !== 1'b0) report_mismatch("afull after reset", level_o.afull, 0);
   if (events_o !== '0) report_mismatch("pulses after reset", events_o, 0);
   if (count_o !== '0) report_mismatch("count_o after reset", count_o, 0);
   if (mem_o !== '0) report_mismatch("memory port after reset", mem_o, 0);
   advance_model(1'b0, 1'b0, 1'b0, 1'b0);   // Idle edge before the first drive
endtask

task automatic fill_to_full();
   int cycles;
   int accepted;
   cycles   = 0;
   accepted = 0;
   // Keep writing until full shows up
   while (level_o.full !== 1'b1 && cycles < FILL_TIMEOUT) begin
      drive_cycle(1'b1, 1'b0);
      if (mem_o.we === 1'b1) begin
         if (mem_o.waddr !== accepted[ADDR_W-1:0])
            report_mismatch("waddr during fill", mem_o.waddr, accepted);
         accepted++;
      end
      cycles++;
   end
   if (level_o.full !== 1'b1) report_problem("full never rose while filling");
   if (accepted != FIFO_DEPTH) report_mismatch("writes accepted", accepted, FIFO_DEPTH);
   // Seen one cycle after the last write, that write itself blocked
   if (cycles != FIFO_DEPTH + 1) report_mismatch("cycles to full", cycles, FIFO_DEPTH + 1);
endtask

task automatic overflow_while_full();
   repeat (3) begin
      drive_cycle(1'b1, 1'b0);
      if (mem_o.we !== 1'b0) report_mismatch("mem_o.we while full", mem_o.we, 0);
      if (events_o.overflow !== 1'b1)
         report_mismatch("overflow pulse", events_o.overflow, 1);
      if (count_o !== FIFO_DEPTH) report_mismatch("count_o while full", count_o, FIFO_DEPTH);
   end
   drive_cycle(1'b0, 1'b0);
   if (events_o.overflow !== 1'b1) report_mismatch("last overflow", events_o.overflow, 1);
   drive_cycle(1'b0, 1'b0);
   if (events_o.overflow !== 1'b0) report_mismatch("overflow idle", events_o.overflow, 0);
endtask

task automatic drain_and_underflow();
   int cycles;
   int accepted;
   cycles   = 0;
   accepted = 0;
   while (level_o.empty !== 1'b1 && cycles < FILL_TIMEOUT) begin
      drive_cycle(1'b0, 1'b1);
      if (mem_o.re === 1'b1) begin
         if (mem_o.raddr !== accepted[ADDR_W-1:0])
            report_mismatch("raddr during drain", mem_o.raddr, accepted);
         accepted++;
      end
      cycles++;
   end
   if (level_o.empty !== 1'b1) report_problem("empty never rose while draining");
   if (accepted != FIFO_DEPTH) report_mismatch("reads accepted", accepted, FIFO_DEPTH);
   if (mem_o.re !== 1'b0) report_mismatch("mem_o.re while empty", mem_o.re, 0);
   drive_cycle(1'b0, 1'b0);
   if (events_o.underflow !== 1'b1)
      report_mismatch("underflow pulse", events_o.underflow, 1);
   if (count_o !== '0) report_mismatch("count_o after drain", count_o, 0);
endtask

task automatic wrap_addresses();
   int  prev_addr;
   logic wrapped;
   prev_addr = -1;
   wrapped   = 1'b0;
   repeat (PART_LEVEL) drive_cycle(1'b1, 1'b0);
   repeat (PART_LEVEL) drive_cycle(1'b0, 1'b1);
   // Write pointer now sits mid memory, so this run crosses the top
   repeat (PART_LEVEL) begin
      drive_cycle(1'b1, 1'b0);
      if (mem_o.we !== 1'b1) report_mismatch("mem_o.we before wrap", mem_o.we, 1);
      if (prev_addr == FIFO_DEPTH - 1 && mem_o.waddr == '0) wrapped = 1'b1;
      prev_addr = mem_o.waddr;
   end
   if (!wrapped) report_problem("write address never wrapped from 1023 to 0");
   repeat (PART_LEVEL - 3) drive_cycle(1'b0, 1'b1);   // Leave a few entries
endtask

task automatic random_mix();
   int r;
   repeat (RANDOM_CYCLES) begin
      r = $random(seed);
      drive_cycle(r[0], r[1]);
   end
   drive_cycle(1'b0, 1'b0);
endtask

/* verif/fifo_sync_tb.sv */
`timescale 1ns/1ps

module fifo_sync_tb;

   import fifo_sync_pkg::*;

   localparam int FILL_TIMEOUT  = FIFO_DEPTH + 16;   // Cycles allowed to reach a flag
   localparam int PART_LEVEL    = 600;               // Partial fill for the wrap test
   localparam int RANDOM_CYCLES = 2000;

   logic         pos_clk;
   logic         aresetn;
   logic         we_i;
   logic         re_i;
   level_flags_t level_o;
   event_flags_t events_o;
   ptr_t         count_o;
   mem_port_t    mem_o;

   // --------------------------------------------------
   // Reference model state
   // --------------------------------------------------

   // Values the DUT registers should hold after the last edge
   int           m_occ;        // Entries held right now
   int           m_waddr;
   int           m_raddr;
   int           m_count;      // Registered occupancy
   logic         m_full;
   logic         m_afull;
   logic         m_empty;
   logic         m_aempty;
   event_flags_t m_events;

   int           err_count;
   int           seed;

   // --------------------------------------------------
   // Clock and DUT
   // --------------------------------------------------
   initial begin
      pos_clk = 1'b0;
   end

   always #20 pos_clk = ~pos_clk;   // 40 ns period

   fifo_sync dut (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .we_i     (we_i),
      .re_i     (re_i),
      .level_o  (level_o),
      .events_o (events_o),
      .count_o  (count_o),
      .mem_o    (mem_o)
   );

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   task automatic reset_model();
      m_occ    = 0;
      m_waddr  = 0;
      m_raddr  = 0;
      m_count  = 0;
      m_full   = 1'b0;
      m_afull  = 1'b0;
      m_empty  = 1'b1;   // Empty side flags come up set
      m_aempty = 1'b1;
      m_events = '0;
   endtask

   // One rising edge with the given requests and accept decisions
   task automatic advance_model(input logic we, input logic re,
                                input logic wacc, input logic racc);
      int occ;
      occ = m_occ;

      // Full looks one write ahead
      if (wacc) begin
         m_full = (occ >= FIFO_DEPTH - 1);
      end else begin
         m_full = (occ >= FIFO_DEPTH);
      end

      // With one entry left an accepted read decides empty
      if (occ == 1) begin
         m_empty = racc;
      end else begin
         m_empty = (occ == 0);
      end

      m_afull  = (occ >= AFULL_VAL - 1);
      m_aempty = (occ <= AEMPTY_VAL + 1);
      m_count  = occ;

      m_events.wack      = wacc;
      m_events.dvld      = racc;
      m_events.overflow  = we & ~wacc;   // Request dropped while full
      m_events.underflow = re & ~racc;

      m_occ   = occ + int'(wacc) - int'(racc);
      m_waddr = (m_waddr + int'(wacc)) % FIFO_DEPTH;
      m_raddr = (m_raddr + int'(racc)) % FIFO_DEPTH;
   endtask

   `include "fifo_sync_tb_tasks.svh"

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      err_count = 0;
      seed      = 84521;
      we_i      = 1'b0;
      re_i      = 1'b0;
      aresetn   = 1'b0;
      reset_model();

      repeat (10) @(posedge pos_clk);
      aresetn <= 1'b1;

      check_reset_state();
      fill_to_full();
      overflow_while_full();
      drain_and_underflow();
      wrap_addresses();
      random_mix();

      $display("Errors: %0d", err_count);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* fifo_sync.f */
+incdir+verif
rtl/fifo_sync_pkg.sv
rtl/fifo_sync_ctrl.sv
rtl/fifo_wr_side.sv
rtl/fifo_rd_side.sv
rtl/fifo_sync.sv
verif/fifo_sync_tb.sv
